/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := rv_core_tb
FILELIST := rv_core.f
OBJ_DIR  := obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* hw/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  inst_word_u            if_inst,
  input  logic [xlen-1:0]       if_pc,
  input  logic                  if_valid,
  input  logic                  redirect,
  input  logic [reg_addr_w-1:0] ex_rd,
  input  logic                  ex_mem_read,
  input  logic                  ex_reg_write,
  input  logic [reg_addr_w-1:0] mem_rd,
  input  logic                  mem_reg_write,
  input  logic [xlen-1:0]       mem_result,
  input  logic                  wb_write,
  input  logic [reg_addr_w-1:0] wb_rd,
  input  logic [xlen-1:0]       wb_data,
  output logic                  stall,
  output logic [ctrl_w-1:0]     id_ctrl,
  output logic [reg_addr_w-1:0] id_rs1,
  output logic [reg_addr_w-1:0] id_rs2,
  output logic [xlen-1:0]       id_rs1_data,
  output logic [xlen-1:0]       id_rs2_data,
  output logic [reg_addr_w-1:0] id_rd,
  output logic [xlen-1:0]       id_imm,
  output logic [xlen-1:0]       id_pc,
  output alu_op_t               id_alu_op,
  output logic                  id_halt,
  output logic [xlen-1:0]       reg_view [32]
);

  logic [ctrl_w-1:0]     ctrl;
  alu_op_t               alu_op;
  logic [xlen-1:0]       imm, rs1_data, rs2_data, ecall_val;
  logic [reg_addr_w-1:0] rf_rs1;
  logic                  uses_rs1, uses_rs2, is_ecall, load_in_mem;
  logic                  load_use, ecall_wait, bubble;

  // funct3 plus the sub/arith bit to an ALU op
  function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      f3_add:  return alt ? alu_sub : alu_add;
      f3_sll:  return alu_sll;
      f3_slt:  return alu_slt;
      f3_sltu: return alu_sltu;
      f3_xor:  return alu_xor;
      f3_srl:  return alt ? alu_sra : alu_srl;
      f3_or:   return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_comb begin
    ctrl     = '0;
    alu_op   = alu_add;  // loads, stores, jalr add rs1 + imm
    imm      = {{20{if_inst.i.imm_11_0[11]}}, if_inst.i.imm_11_0};  // i-type
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (if_inst.r.opcode)
      op_reg: begin
        ctrl[ctrl_reg_write] = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        alu_op   = arith_op(if_inst.r.funct3, if_inst.r.funct7[5]);
      end
      op_imm: begin
        ctrl[ctrl_reg_write] = 1'b1;
        ctrl[ctrl_alu_src]   = 1'b1;
        uses_rs1 = 1'b1;
        // funct7 is immediate bits except for srai
        alu_op = arith_op(if_inst.r.funct3,
                          if_inst.r.funct3 == f3_srl && if_inst.r.funct7[5]);
      end
      op_load: begin
        ctrl[ctrl_reg_write] = 1'b1;
        ctrl[ctrl_mem_read]  = 1'b1;
        ctrl[ctrl_alu_src]   = 1'b1;
        uses_rs1 = 1'b1;
      end
      op_store: begin
        ctrl[ctrl_mem_write] = 1'b1;
        ctrl[ctrl_alu_src]   = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        imm = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
      end
      op_branch: begin
        ctrl[ctrl_branch] = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        imm = {{19{if_inst[31]}}, if_inst[31], if_inst[7], if_inst[30:25],
               if_inst[11:8], 1'b0};
        case (if_inst.r.funct3)
          f3_bne:  alu_op = alu_ne;
          f3_blt:  alu_op = alu_lt;
          f3_bge:  alu_op = alu_ge;
          default: alu_op = alu_eq;  // beq
        endcase
      end
      op_jal: begin
        ctrl[ctrl_reg_write] = 1'b1;
        ctrl[ctrl_jal]       = 1'b1;
        imm = {{11{if_inst[31]}}, if_inst[31], if_inst[19:12], if_inst[20],
               if_inst[30:21], 1'b0};
      end
      op_jalr: begin
        ctrl[ctrl_reg_write] = 1'b1;
        ctrl[ctrl_jalr]      = 1'b1;
        ctrl[ctrl_alu_src]   = 1'b1;
        uses_rs1 = 1'b1;
      end
      default: ;  // ecall and unknowns carry no control
    endcase
  end

  assign is_ecall = if_valid && if_inst.r.opcode == op_system;
  assign rf_rs1   = is_ecall ? ecall_arg_reg : if_inst.r.rs1;  // ecall reads a7

  register_file regfile_inst (
    .clk, .reset,
    .rs1      (rf_rs1),
    .rs2      (if_inst.r.rs2),
    .rd       (wb_rd),
    .rd_data  (wb_data),
    .write    (wb_write),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .view     (reg_view)
  );

  // EX/MEM holds a load, its result is not ready for forwarding
  always_ff @(posedge clk) begin
    if (reset)
      load_in_mem <= 1'b0;
    else
      load_in_mem <= ex_mem_read;
  end

  // a7 as seen by ecall, memory stage first, writeback via the file
  assign ecall_val = (mem_reg_write && mem_rd == ecall_arg_reg && !load_in_mem)
                     ? mem_result : rs1_data;

  assign load_use = ex_mem_read && ex_rd != '0 &&
                    ((uses_rs1 && ex_rd == if_inst.r.rs1) ||
                     (uses_rs2 && ex_rd == if_inst.r.rs2));
  // a7 writer in execute, or a7 load still in memory
  assign ecall_wait = is_ecall &&
                      ((ex_reg_write && ex_rd == ecall_arg_reg) ||
                       (load_in_mem && mem_reg_write && mem_rd == ecall_arg_reg));

  assign stall  = if_valid && (load_use || ecall_wait) && !redirect;  // squash wins
  assign bubble = !if_valid || stall || redirect;

  // ID/EX control
  always_ff @(posedge clk) begin
    if (reset || bubble) begin
      id_ctrl <= '0;
      id_halt <= 1'b0;
    end else begin
      id_ctrl <= ctrl;
      id_halt <= is_ecall && ecall_val == ecall_halt_code;
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    id_rs1      <= if_inst.i.rs1;
    id_rs2      <= if_inst.r.rs2;
    id_rd       <= if_inst.i.rd;
    id_rs1_data <= rs1_data;
    id_rs2_data <= rs2_data;
    id_imm      <= imm;
    id_pc       <= if_pc;
    id_alu_op   <= alu_op;
  end

  // word fetched under a taken transfer also leaves decode as a bubble
  a_bubble_clean: assert property (@(posedge clk) disable iff (reset)
    $past(redirect, 2) |-> !id_ctrl[ctrl_reg_write] && !id_ctrl[ctrl_mem_write]);

endmodule

/* hw/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [ctrl_w-1:0]     id_ctrl,
  input  logic [reg_addr_w-1:0] id_rs1,
  input  logic [reg_addr_w-1:0] id_rs2,
  input  logic [xlen-1:0]       id_rs1_data,
  input  logic [xlen-1:0]       id_rs2_data,
  input  logic [reg_addr_w-1:0] id_rd,
  input  logic [xlen-1:0]       id_imm,
  input  logic [xlen-1:0]       id_pc,
  input  alu_op_t               id_alu_op,
  input  logic                  id_halt,
  input  logic                  wb_write,
  input  logic [reg_addr_w-1:0] wb_rd,
  input  logic [xlen-1:0]       wb_data,
  output logic                  redirect,
  output logic [xlen-1:0]       redirect_target,
  output logic [ctrl_w-1:0]     mem_ctrl,
  output logic [xlen-1:0]       mem_result,
  output logic [xlen-1:0]       mem_store_data,
  output logic [reg_addr_w-1:0] mem_rd,
  output logic [xlen-1:0]       mem_pc,
  output logic                  mem_halt
);

  logic [xlen-1:0] op_a, op_b_reg, op_b, alu_out;

  // newest producer wins, memory over writeback
  function automatic logic [xlen-1:0] fwd_operand(input logic [reg_addr_w-1:0] rs,
                                                  input logic [xlen-1:0] rf_data);
    if (rs != '0 && mem_ctrl[ctrl_reg_write] && mem_rd == rs)
      return mem_result;
    if (rs != '0 && wb_write && wb_rd == rs)
      return wb_data;
    return rf_data;
  endfunction

  always_comb begin
    op_a     = fwd_operand(id_rs1, id_rs1_data);
    op_b_reg = fwd_operand(id_rs2, id_rs2_data);  // also the store data
  end

  assign op_b = id_ctrl[ctrl_alu_src] ? id_imm : op_b_reg;

  always_comb begin
    case (id_alu_op)
      alu_add:  alu_out = op_a + op_b;
      alu_sub:  alu_out = op_a - op_b;
      alu_and:  alu_out = op_a & op_b;
      alu_or:   alu_out = op_a | op_b;
      alu_xor:  alu_out = op_a ^ op_b;
      alu_slt:  alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_out = {31'b0, op_a < op_b};
      alu_sll:  alu_out = op_a << op_b[4:0];
      alu_srl:  alu_out = op_a >> op_b[4:0];
      alu_sra:  alu_out = $signed(op_a) >>> op_b[4:0];
      alu_eq:   alu_out = {31'b0, op_a == op_b};
      alu_ne:   alu_out = {31'b0, op_a != op_b};
      alu_lt:   alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_ge:   alu_out = {31'b0, $signed(op_a) >= $signed(op_b)};
      default:  alu_out = '0;
    endcase
  end

  // fetch guessed not-taken, so any taken transfer redirects
  assign redirect = (id_ctrl[ctrl_branch] && alu_out[0]) ||
                    id_ctrl[ctrl_jal] || id_ctrl[ctrl_jalr];
  assign redirect_target = id_ctrl[ctrl_jalr] ? {alu_out[xlen-1:1], 1'b0}  // rs1 + imm
                                              : id_pc + id_imm;

  // EX/MEM control
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_ctrl <= '0;
      mem_halt <= 1'b0;
    end else begin
      mem_ctrl <= id_ctrl;
      mem_halt <= id_halt;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    mem_result     <= alu_out;
    mem_store_data <= op_b_reg;
    mem_rd         <= id_rd;
    mem_pc         <= id_pc;
  end

  // redirect comes from a transfer and is followed by the squashed slot
  a_redirect_strobe: assert property (@(posedge clk) disable iff (reset)
    redirect |-> (id_ctrl[ctrl_branch] || id_ctrl[ctrl_jal] || id_ctrl[ctrl_jalr])
                 ##1 !redirect);

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import rv_pkg::*; #(
  parameter int imem_depth = 256
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            imem_write,
  input  logic [xlen-1:0] imem_addr,  // byte address, low two bits ignored
  input  logic [xlen-1:0] imem_data,
  input  logic            stall,
  input  logic            redirect,
  input  logic [xlen-1:0] redirect_target,
  output inst_word_u      if_inst,
  output logic [xlen-1:0] if_pc,
  output logic            if_valid
);

  localparam int iaw = $clog2(imem_depth);

  logic [xlen-1:0] imem [imem_depth];
  logic [xlen-1:0] pc;

  // program load port
  always_ff @(posedge clk) begin
    if (imem_write)
      imem[imem_addr[iaw+1:2]] <= imem_data;
  end

  // pc and IF/ID valid
  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= '0;
      if_valid <= 1'b0;
    end else if (redirect) begin
      pc       <= redirect_target;
      if_valid <= 1'b0;  // squash the word fetched under the branch
    end else if (!stall) begin
      pc       <= pc + 32'd4;  // always predict not-taken
      if_valid <= 1'b1;
    end
  end

  // IF/ID payload, held while decode stalls
  always_ff @(posedge clk) begin
    if (!stall) begin
      if_inst <= imem[pc[iaw+1:2]];
      if_pc   <= pc;
    end
  end

  // decode never asks for a hold while execute is steering fetch
  a_stall_vs_redirect: assert property (@(posedge clk) disable iff (reset)
    !(stall && redirect));

endmodule

/* hw/memory_writeback.sv */
`timescale 1ns/1ps

module memory_writeback import rv_pkg::*; #(
  parameter int dmem_depth = 256
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [ctrl_w-1:0]     mem_ctrl,
  input  logic [xlen-1:0]       mem_result,  // also the byte address
  input  logic [xlen-1:0]       mem_store_data,
  input  logic [reg_addr_w-1:0] mem_rd,
  input  logic [xlen-1:0]       mem_pc,
  input  logic                  mem_halt,
  output logic                  wb_write,
  output logic [reg_addr_w-1:0] wb_rd,
  output logic [xlen-1:0]       wb_data,
  output logic                  is_halted
);

  localparam int daw = $clog2(dmem_depth);

  logic [xlen-1:0] dmem [dmem_depth];
  logic [xlen-1:0] load_data;
  logic            wb_halt;

  // word stores only
  always_ff @(posedge clk) begin
    if (mem_ctrl[ctrl_mem_write])
      dmem[mem_result[daw+1:2]] <= mem_store_data;
  end

  assign load_data = dmem[mem_result[daw+1:2]];  // combinational read

  // MEM/WB control and sticky halt
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_write  <= 1'b0;
      wb_halt   <= 1'b0;
      is_halted <= 1'b0;
    end else begin
      wb_write  <= mem_ctrl[ctrl_reg_write];
      wb_halt   <= mem_halt;
      is_halted <= is_halted || wb_halt;  // held until reset
    end
  end

  // MEM/WB payload, result already selected
  always_ff @(posedge clk) begin
    wb_rd <= mem_rd;
    if (mem_ctrl[ctrl_jal] || mem_ctrl[ctrl_jalr])
      wb_data <= mem_pc + 32'd4;  // link
    else if (mem_ctrl[ctrl_mem_read])
      wb_data <= load_data;
    else
      wb_data <= mem_result;
  end

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ps

module register_file import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  input  logic [reg_addr_w-1:0] rd,
  input  logic [xlen-1:0]       rd_data,
  input  logic                  write,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data,
  output logic [xlen-1:0]       view [32]
);

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (write && rd != '0) begin  // x0 stays zero
      regs[rd] <= rd_data;
    end
  end

  // write-through, so writeback lands before the read
  assign rs1_data = (rs1 == '0) ? '0 : (write && rd == rs1) ? rd_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : (write && rd == rs2) ? rd_data : regs[rs2];

  assign view = regs;

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
  parameter int imem_depth = 256,  // words
  parameter int dmem_depth = 256
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            imem_write,
  input  logic [xlen-1:0] imem_addr,  // byte address
  input  logic [xlen-1:0] imem_data,
  output logic            is_halted,
  output logic [xlen-1:0] reg_view [32]
);

  // fetch to decode
  inst_word_u      if_inst;
  logic [xlen-1:0] if_pc;
  logic            if_valid;
  logic            stall;

  // redirect from execute
  logic            redirect;
  logic [xlen-1:0] redirect_target;

  // ID/EX
  logic [ctrl_w-1:0]     id_ctrl;
  logic [reg_addr_w-1:0] id_rs1, id_rs2, id_rd;
  logic [xlen-1:0]       id_rs1_data, id_rs2_data, id_imm, id_pc;
  alu_op_t               id_alu_op;
  logic                  id_halt;

  // EX/MEM
  logic [ctrl_w-1:0]     mem_ctrl;
  logic [xlen-1:0]       mem_result, mem_store_data, mem_pc;
  logic [reg_addr_w-1:0] mem_rd;
  logic                  mem_halt;

  // writeback port
  logic                  wb_write;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0]       wb_data;

  fetch_unit #(.imem_depth(imem_depth)) fetch_inst (
    .clk, .reset,
    .imem_write, .imem_addr, .imem_data,
    .stall, .redirect, .redirect_target,
    .if_inst, .if_pc, .if_valid
  );

  decode_unit decode_inst (
    .clk, .reset,
    .if_inst, .if_pc, .if_valid,
    .redirect,
    .ex_rd        (id_rd),
    .ex_mem_read  (id_ctrl[ctrl_mem_read]),
    .ex_reg_write (id_ctrl[ctrl_reg_write]),
    .mem_rd,
    .mem_reg_write(mem_ctrl[ctrl_reg_write]),
    .mem_result,
    .wb_write, .wb_rd, .wb_data,
    .stall,
    .id_ctrl, .id_rs1, .id_rs2, .id_rs1_data, .id_rs2_data,
    .id_rd, .id_imm, .id_pc, .id_alu_op, .id_halt,
    .reg_view
  );

  execute_unit execute_inst (
    .clk, .reset,
    .id_ctrl, .id_rs1, .id_rs2, .id_rs1_data, .id_rs2_data,
    .id_rd, .id_imm, .id_pc, .id_alu_op, .id_halt,
    .wb_write, .wb_rd, .wb_data,
    .redirect, .redirect_target,
    .mem_ctrl, .mem_result, .mem_store_data, .mem_rd, .mem_pc, .mem_halt
  );

  memory_writeback #(.dmem_depth(dmem_depth)) memwb_inst (
    .clk, .reset,
    .mem_ctrl, .mem_result, .mem_store_data, .mem_rd, .mem_pc, .mem_halt,
    .wb_write, .wb_rd, .wb_data,
    .is_halted
  );

endmodule

/* hw/rv_pkg.sv */
package rv_pkg;

  localparam int xlen       = 32;  // data and address width
  localparam int reg_addr_w = 5;

  // major opcodes, bits [6:0]
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 for arithmetic
  localparam logic [2:0] f3_add  = 3'b000;  // add / sub
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101;  // srl / sra
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct3 for branches
  localparam logic [2:0] f3_beq = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_blt = 3'b100;
  localparam logic [2:0] f3_bge = 3'b101;

  // bit positions inside the control vector carried down the pipe
  localparam int ctrl_reg_write = 0;
  localparam int ctrl_mem_read  = 1;
  localparam int ctrl_mem_write = 2;
  localparam int ctrl_alu_src   = 3;  // operand b from immediate
  localparam int ctrl_branch    = 4;
  localparam int ctrl_jal       = 5;
  localparam int ctrl_jalr      = 6;
  localparam int ctrl_w         = 7;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sltu,
    alu_sll, alu_srl, alu_sra,
    alu_eq, alu_ne, alu_lt, alu_ge  // branch compares, result in bit 0
  } alu_op_t;

  // one fetched word, seen as r-type or i-type
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } inst_word_u;

  localparam logic [xlen-1:0]       ecall_halt_code = 32'd10;
  localparam logic [reg_addr_w-1:0] ecall_arg_reg   = 5'd17;  // a7

endpackage

/* rv_core.f */
+incdir+test
hw/rv_pkg.sv
hw/register_file.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/memory_writeback.sv
hw/rv_core.sv
test/rv_core_tb.sv

/* test/rv_programs.svh */
`ifndef rv_programs_svh
`define rv_programs_svh

// one row per test, code starts at byte address 0 and ends in a halting ecall
// words past prog_len are not loaded, the loader fills them with nops
localparam int num_tests  = 5;
localparam int max_insts  = 18;
localparam int max_checks = 8;

string test_names [num_tests] = '{
  "alu_forwarding", "load_store", "branches", "jumps", "ecall_no_halt"
};

int prog_len [num_tests] = '{12, 12, 18, 12, 13};

logic [31:0] prog_words [num_tests][max_insts] = '{
  '{32'h00500093, 32'h00308113, 32'h002081b3, 32'h40118233,  // addi add sub chain
    32'hfff00293, 32'h00524333, 32'h40235393, 32'h00132433,  // xor srai slt
    32'h0060b4b3, 32'h00409513, 32'h00a00893, 32'h00000073,  // sltu slli, halt
    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
  '{32'h04000093, 32'h12300113, 32'h0020a023, 32'h0010a223,  // base 64, two stores
    32'h0000a183, 32'h00118213, 32'h0040a283, 32'h00428333,  // load then use
    32'h0060a423, 32'h0080a383, 32'h00a00893, 32'h00000073,
    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
  '{32'h00300093, 32'h00300113, 32'h00208463, 32'h00100513,  // beq taken
    32'h00209463, 32'h00700193, 32'h00104463, 32'h00100593,  // bne not, blt taken
    32'h00105463, 32'h00900213, 32'hffe00293, 32'h0002c663,  // bge not, blt neg
    32'h00100613, 32'h00100693, 32'h0050d463, 32'h00100713,  // bge taken
    32'h00a00893, 32'h00000073},
  '{32'h00c000ef, 32'h00100513, 32'h00100593, 32'h01c00113,  // jal x1 over two
    32'h000101e7, 32'h00100613, 32'h00100693, 32'h06418213,  // jalr x3 to 28
    32'h0080006f, 32'h00100713, 32'h00a00893, 32'h00000073,  // jal x0
    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
  '{32'h04000093, 32'h00a00113, 32'h0020a023, 32'h00a00893,  // a7 = 10 in writeback
    32'h00500893, 32'h00000073, 32'h00100193, 32'h00b00893,  // a7 = 5, ecall, a7 = 11
    32'h00200213, 32'h00000073, 32'h00300293, 32'h0000a883,  // ecall, a7 loaded as 10
    32'h00000073, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0}
};

// register index and its value once the halt is seen
int exp_reg [num_tests][max_checks] = '{
  '{2, 3, 4, 6, 7, 8, 9, 10},
  '{1, 2, 3, 4, 5, 6, 7, 17},
  '{3, 4, 5, 10, 11, 12, 13, 14},  // x10 up are markers
  '{1, 3, 4, 10, 11, 12, 13, 14},
  '{0, 1, 2, 3, 4, 5, 6, 17}
};

logic [31:0] exp_val [num_tests][max_checks] = '{
  '{32'h8, 32'hd, 32'h8, 32'hfffffff7, 32'hfffffffd, 32'h1, 32'h1, 32'h50},
  '{32'h40, 32'h123, 32'h123, 32'h124, 32'h40, 32'h164, 32'h164, 32'ha},
  '{32'h7, 32'h9, 32'hfffffffe, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
  '{32'h4, 32'h14, 32'h78, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
  '{32'h0, 32'h40, 32'ha, 32'h1, 32'h2, 32'h3, 32'h0, 32'ha}
};

`endif

/* test/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

  localparam int imem_depth  = 256;  // words
  localparam int dmem_depth  = 256;
  localparam int halt_limit  = 2000;  // cycles per program

  logic        clk;
  logic        reset;
  logic        imem_write;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        is_halted;
  logic [31:0] reg_view [32];

  `include "rv_programs.svh"

  rv_core #(
    .imem_depth(imem_depth),
    .dmem_depth(dmem_depth)
  ) rv_core_inst (
    .clk, .reset,
    .imem_write, .imem_addr, .imem_data,
    .is_halted, .reg_view
  );

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)  // x or z counts as wrong
      fail_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
  endtask

  // whole imem rewritten, program first and nops after it
  task automatic load_program(input int t);
    logic [31:0] word;
    logic [31:0] rnd;
    for (int i = 0; i < imem_depth; i++) begin
      rnd = $urandom;
      if (i < prog_len[t])
        word = prog_words[t][i];
      else
        word = {rnd[11:0], 20'h00013};  // addi x0, x0, random imm
      @(negedge clk);
      imem_write = 1'b1;
      imem_addr  = i * 4;  // byte address
      imem_data  = word;
    end
    @(negedge clk);
    imem_write = 1'b0;
  endtask

  // state seen while reset is still high
  task automatic check_reset_state(input int t);
    check_value($sformatf("%s is_halted after reset", test_names[t]),
                32'h0, {31'h0, is_halted});
    for (int r = 0; r < 32; r++)
      check_value($sformatf("%s x%0d after reset", test_names[t], r), 32'h0, reg_view[r]);
  endtask

  task automatic wait_for_halt(input int t);
    int cycles;
    cycles = 0;
    while (!is_halted) begin
      @(negedge clk);  // sample away from the active edge
      cycles++;
      if (cycles >= halt_limit)
        fail_run($sformatf("program %s did not halt within %0d cycles",
                           test_names[t], halt_limit));
    end
  endtask

  task automatic check_registers(input int t);
    int r;
    for (int c = 0; c < max_checks; c++) begin
      r = exp_reg[t][c];
      check_value($sformatf("%s x%0d", test_names[t], r), exp_val[t][c], reg_view[r]);
    end
  endtask

  initial begin
    void'($urandom(32'ha1d5_7d97));  // one seed for the run
    reset      = 1'b1;
    imem_write = 1'b0;
    imem_addr  = 32'h0;
    imem_data  = 32'h0;
    for (int t = 0; t < num_tests; t++) begin
      reset = 1'b1;
      repeat (4) @(negedge clk);  // reset cycles, load keeps reset high
      load_program(t);
      check_reset_state(t);
      reset = 1'b0;  // on a falling edge
      wait_for_halt(t);
      check_registers(t);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule
